/* filelist.f */
rtl/prefetch_pkg.sv
rtl/fetch_ctrl.sv
rtl/fetch_queue.sv
rtl/instr_aligner.sv
rtl/prefetch_buffer.sv
verif/prefetch_buffer_chk.sv
verif/tb_prefetch_buffer.sv

/* Bender.yml */
package:
  name: prefetch_buffer

sources:
  # design, package first
  - files:
      - rtl/prefetch_pkg.sv
      - rtl/fetch_ctrl.sv
      - rtl/fetch_queue.sv
      - rtl/instr_aligner.sv
      - rtl/prefetch_buffer.sv

  # verification only
  - target: test
    files:
      - verif/prefetch_buffer_chk.sv
      - verif/tb_prefetch_buffer.sv

/* verif/tb_prefetch_buffer.sv */
// testbench for the prefetch buffer: memory responder, halfword walk model and directed tests
`default_nettype none

module tb_prefetch_buffer;

  timeunit 1ns;
  timeprecision 100ps;

  import prefetch_pkg::*;

  logic  clk;
  logic  rst_n;
  logic  req_i;
  logic  branch_i;
  addr_t addr_i;
  logic  ready_i;
  logic  valid_o;
  word_t rdata_o;
  addr_t addr_o;
  logic  instr_req_o;
  logic  instr_gnt_i;
  addr_t instr_addr_o;
  word_t instr_rdata_i;
  logic  instr_rvalid_i;
  logic  busy_o;

  // memory content select, 0 is 32-bit only, 1 is mixed
  int          pattern = 0;
  logic [31:0] gnt_seed = 32'ha8e5;
  logic [31:0] rdy_seed = 32'ha8e5 ^ 32'h5555;
  int          gnt_wait = 0;
  logic        rnd_ready = 1'b0;

  // reference walk state
  logic  walk_on = 1'b0;
  addr_t exp_pc = '0;
  int    taken_cnt = 0;
  int    straddle_cnt = 0;

  // output hold tracking while ready_i is low
  logic  held = 1'b0;
  addr_t held_addr;
  word_t held_data;
  word_t held_mask;

  int errors = 0;
  int errs_seen = 0;
  int tests_run = 0;
  int tests_failed = 0;

  prefetch_buffer UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .addr_i         (addr_i),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .rdata_o        (rdata_o),
    .addr_o         (addr_o),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .busy_o         (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // stimulus helpers and memory model
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // one parcel per halfword address, low bits pick 16 or 32 bit
  function automatic logic [15:0] half_at(input addr_t a);
    logic [31:0] x;
    x = a ^ (a >> 13);
    x = x * 32'h9e37_79b1;
    x = x ^ (x >> 16);
    if (pattern == 0) begin
      return {x[15:2], 2'b11};
    end
    if (x[9]) begin
      return {x[15:2], 2'b11};
    end
    return {x[15:2], x[7], 1'b0};
  endfunction

  function automatic word_t word_at(input addr_t a);
    return {half_at({a[31:2], 2'b10}), half_at({a[31:2], 2'b00})};
  endfunction

  task automatic show_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("FAIL %s: expected 0x%08h, got 0x%08h at %0t", name, expected, actual, $time);
    errors++;
  endtask

  task automatic log_problem(input string msg);
    $display("error: %s at %0t", msg, $time);
    errors++;
  endtask

  task automatic close_test(input string name);
    int n;
    n = errors - errs_seen;
    errs_seen = errors;
    tests_run++;
    if (n == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, n);
    end
  endtask

  //////////////////////////////////////////////////
  // memory responder and ready driver
  //////////////////////////////////////////////////

  // grant after 0 to 3 cycles, rvalid one cycle after the grant
  always @(posedge clk) begin
    instr_rvalid_i <= 1'b0;
    if (rst_n) begin
      if (instr_req_o && instr_gnt_i) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= word_at(instr_addr_o);
        gnt_seed = lcg_step(gnt_seed);
        gnt_wait = int'(gnt_seed[21:20]);
        instr_gnt_i <= (gnt_wait == 0);
      end else if (instr_req_o) begin
        if (gnt_wait <= 1) begin
          instr_gnt_i <= 1'b1;
        end else begin
          gnt_wait = gnt_wait - 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rnd_ready) begin
      rdy_seed = lcg_step(rdy_seed);
      ready_i <= rdy_seed[17];
    end
  end

  //////////////////////////////////////////////////
  // output monitor, sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin : walk_monitor
    logic [15:0] lo_h;
    logic [15:0] hi_h;
    logic        wide;
    if (rst_n) begin
      // outputs must not move while the core stalls
      if (held) begin
        assert (valid_o) else log_problem("valid_o dropped while ready_i was low");
        assert (addr_o == held_addr) else show_mismatch("addr_o", held_addr, addr_o);
        assert ((rdata_o & held_mask) == held_data)
          else show_mismatch("rdata_o", held_data, rdata_o & held_mask);
      end
      lo_h      = half_at(addr_o);
      held      = valid_o && !ready_i && !branch_i;
      held_addr = addr_o;
      held_mask = (lo_h[1:0] == 2'b11) ? 32'hffff_ffff : 32'h0000_ffff;
      held_data = rdata_o & held_mask;

      // a fetch is outstanding from its request until its rvalid
      assert (busy_o == (instr_req_o || instr_rvalid_i))
        else show_mismatch("busy_o", instr_req_o || instr_rvalid_i, busy_o);

      // taken instruction against the halfword walk
      if (walk_on && valid_o && ready_i) begin
        lo_h = half_at(exp_pc);
        hi_h = half_at(exp_pc + 32'd2);
        wide = (lo_h[1:0] == 2'b11);
        assert (addr_o == exp_pc) else show_mismatch("addr_o", exp_pc, addr_o);
        if (wide) begin
          assert (rdata_o == {hi_h, lo_h}) else show_mismatch("rdata_o", {hi_h, lo_h}, rdata_o);
        end else begin
          assert (rdata_o[15:0] == lo_h) else show_mismatch("rdata_o", lo_h, rdata_o[15:0]);
        end
        if (wide && exp_pc[1]) begin
          straddle_cnt++;
        end
        exp_pc = exp_pc + (wide ? 32'd4 : 32'd2);
        taken_cnt++;
      end
    end
  end

  //////////////////////////////////////////////////
  // sequencing tasks
  //////////////////////////////////////////////////

  // one branch cycle with ready_i low, walk restarts at target
  task automatic jump_to(input addr_t target, input int pat);
    @(posedge clk);
    req_i    <= 1'b1;
    branch_i <= 1'b1;
    addr_i   <= target;
    ready_i  <= 1'b0;
    pattern      = pat;
    exp_pc       = target;
    taken_cnt    = 0;
    straddle_cnt = 0;
    walk_on      = 1'b1;
    @(posedge clk);
    branch_i <= 1'b0;
    ready_i  <= 1'b1;
  endtask

  task automatic wait_taken(input int n, input int limit);
    int cyc;
    cyc = 0;
    while (taken_cnt < n && cyc < limit) begin
      @(posedge clk);
      cyc++;
    end
    assert (taken_cnt >= n)
      else log_problem($sformatf("timeout, %0d of %0d instructions delivered", taken_cnt, n));
  endtask

  task automatic catch_grant(input int limit);
    int cyc;
    cyc = 0;
    do begin
      @(negedge clk);
      cyc++;
    end while (!(instr_req_o && instr_gnt_i) && cyc < limit);
    assert (instr_req_o && instr_gnt_i) else log_problem("timeout waiting for a memory grant");
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic idle_after_reset();
    repeat (10) begin
      @(negedge clk);
      assert (!instr_req_o) else show_mismatch("instr_req_o", 32'h0, instr_req_o);
      assert (!valid_o) else show_mismatch("valid_o", 32'h0, valid_o);
      assert (!busy_o) else show_mismatch("busy_o", 32'h0, busy_o);
    end
    close_test("idle after reset");
  endtask

  task automatic aligned_stream();
    jump_to(32'h0000_0100, 0);
    wait_taken(24, 400);
    close_test("aligned 32-bit stream");
  endtask

  task automatic mixed_stream();
    jump_to(32'h0000_1000, 1);
    wait_taken(40, 600);
    assert (straddle_cnt > 0) else log_problem("mixed stream had no word-straddling instruction");
    close_test("mixed compressed stream");
  endtask

  // branch lands in the rvalid cycle of an outstanding fetch
  task automatic unaligned_branch();
    jump_to(32'h0000_3000, 1);
    wait_taken(8, 200);
    catch_grant(100);
    jump_to(32'h0000_4006, 1);
    wait_taken(30, 600);
    close_test("unaligned branch over outstanding fetch");
  endtask

  task automatic random_ready();
    jump_to(32'h0000_5002, 1);
    // stall first so the queue fills up
    @(posedge clk);
    ready_i <= 1'b0;
    repeat (20) @(posedge clk);
    @(negedge clk);
    rnd_ready = 1'b1;
    wait_taken(200, 4000);
    @(negedge clk);
    rnd_ready = 1'b0;
    close_test("random ready long stream");
  endtask

  initial begin
    req_i          = 1'b0;
    branch_i       = 1'b0;
    addr_i         = '0;
    ready_i        = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    rst_n          = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    idle_after_reset();
    aligned_stream();
    mixed_stream();
    unaligned_branch();
    random_ready();

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/prefetch_buffer_chk.sv */
// protocol checker for the memory port and fetch queue, bound into the prefetch buffer top level
`default_nettype none

module prefetch_buffer_chk (
  input wire logic                                  clk,
  input wire logic                                  rst_n,
  input wire logic                                  instr_req_i,
  input wire logic                                  instr_gnt_i,
  input wire prefetch_pkg::addr_t                   instr_addr_i,
  input wire logic                                  instr_rvalid_i,
  input wire logic                                  branch_i,
  input wire logic                                  push_i,
  input wire logic [prefetch_pkg::QUEUE_DEPTH-1:0]  queue_valid_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // one granted request waiting for its rvalid
  logic outstanding_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= 1'b0;
    end else if (instr_req_i && instr_gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // memory port
  //////////////////////////////////////////////////

  rvalid_has_request: assert property (
    @(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> outstanding_q
  ) else $error("rvalid without an outstanding request");

  // only a branch may replace an ungranted address
  addr_holds_until_gnt: assert property (
    @(posedge clk) disable iff (!rst_n)
    (instr_req_i && !instr_gnt_i) |=> instr_req_i && (branch_i || $stable(instr_addr_i))
  ) else $error("instr_addr_o changed while waiting for a grant");

  //////////////////////////////////////////////////
  // fetch queue
  //////////////////////////////////////////////////

  no_push_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    push_i |-> !(&queue_valid_i)
  ) else $error("fetch queue pushed while full");

endmodule

bind prefetch_buffer prefetch_buffer_chk u_prefetch_buffer_chk (
  .clk            (clk),
  .rst_n          (rst_n),
  .instr_req_i    (instr_req_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_addr_i   (instr_addr_o),
  .instr_rvalid_i (instr_rvalid_i),
  .branch_i       (branch_i),
  .push_i         (push),
  .queue_valid_i  (u_fetch_queue.valid_q)
);

`default_nettype wire

/* rtl/prefetch_buffer.sv */
// prefetch buffer top level: fetch controller, fetch queue and aligner chained between memory and core
`default_nettype none

module prefetch_buffer (
  input  wire logic                 clk,
  input  wire logic                 rst_n,

  // core side
  input  wire logic                 req_i,
  input  wire logic                 branch_i,
  input  wire prefetch_pkg::addr_t  addr_i,
  input  wire logic                 ready_i,
  output logic                      valid_o,
  output prefetch_pkg::word_t       rdata_o,
  output prefetch_pkg::addr_t       addr_o,

  // instruction memory port
  output logic                      instr_req_o,
  input  wire logic                 instr_gnt_i,
  output prefetch_pkg::addr_t       instr_addr_o,
  input  wire prefetch_pkg::word_t  instr_rdata_i,
  input  wire logic                 instr_rvalid_i,

  // a fetch is outstanding
  output logic                      busy_o
);

  import prefetch_pkg::*;

  // controller <-> queue
  logic  queue_space;
  logic  push;
  addr_t push_addr;
  logic  clear;

  // queue <-> aligner
  word_t head;
  logic  head_valid;
  logic  head_stored;
  word_t second;
  logic  second_valid;
  addr_t in_addr;
  logic  pop;

  //////////////////////////////////////////////////
  // stage one, memory side
  //////////////////////////////////////////////////

  fetch_ctrl u_fetch_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .addr_i         (addr_i),
    .queue_space_i  (queue_space),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .push_o         (push),
    .push_addr_o    (push_addr),
    .clear_o        (clear),
    .busy_o         (busy_o)
  );

  //////////////////////////////////////////////////
  // stage two, word queue
  //////////////////////////////////////////////////

  fetch_queue u_fetch_queue (
    .clk            (clk),
    .rst_n          (rst_n),
    .clear_i        (clear),
    .push_i         (push),
    .push_addr_i    (push_addr),
    .push_data_i    (instr_rdata_i),
    .pop_i          (pop),
    .space_o        (queue_space),
    .head_o         (head),
    .head_valid_o   (head_valid),
    .head_stored_o  (head_stored),
    .second_o       (second),
    .second_valid_o (second_valid),
    .in_addr_o      (in_addr)
  );

  //////////////////////////////////////////////////
  // stage three, core side
  //////////////////////////////////////////////////

  instr_aligner u_instr_aligner (
    .clk            (clk),
    .rst_n          (rst_n),
    .head_i         (head),
    .head_valid_i   (head_valid),
    .head_stored_i  (head_stored),
    .second_i       (second),
    .second_valid_i (second_valid),
    .in_addr_i      (in_addr),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .rdata_o        (rdata_o),
    .addr_o         (addr_o),
    .pop_o          (pop)
  );

endmodule

`default_nettype wire

/* rtl/instr_aligner.sv */
// instruction aligner: tracks the halfword pc and cuts aligned, unaligned and compressed instructions
`default_nettype none

module instr_aligner (
  input  wire logic                 clk,
  input  wire logic                 rst_n,

  // from the fetch queue
  input  wire prefetch_pkg::word_t  head_i,
  input  wire logic                 head_valid_i,
  input  wire logic                 head_stored_i,
  input  wire prefetch_pkg::word_t  second_i,
  input  wire logic                 second_valid_i,
  input  wire prefetch_pkg::addr_t  in_addr_i,

  // core side
  input  wire logic                 ready_i,
  output logic                      valid_o,
  output prefetch_pkg::word_t       rdata_o,
  output prefetch_pkg::addr_t       addr_o,

  // to the fetch queue
  output logic                      pop_o
);

  import prefetch_pkg::*;

  addr_t pc_q;
  addr_t pc_cur;
  addr_t pc_next;
  // first word address after the head
  addr_t word_next;
  logic  unaligned;
  logic  compressed;
  logic  taken;

  // a bypassed head carries its own address
  assign pc_cur    = head_stored_i ? pc_q : in_addr_i;
  assign unaligned = pc_cur[1];
  assign word_next = {pc_cur[ADDR_W-1:2], 2'b00} + addr_t'(WORD_BYTES);

  //////////////////////////////////////////////////
  // instruction select
  //////////////////////////////////////////////////

  always_comb begin
    if (unaligned) begin
      // upper parcel of the head, lower parcel of the next word
      rdata_o    = {second_i[HALF_W-1:0], head_i[WORD_W-1:HALF_W]};
      compressed = head_i[HALF_W+1:HALF_W] != 2'b11;
      // a 32-bit instruction straddles into the second word
      valid_o    = head_valid_i & (compressed | second_valid_i);
    end else begin
      rdata_o    = head_i;
      compressed = head_i[1:0] != 2'b11;
      valid_o    = head_valid_i;
    end
  end

  assign addr_o = pc_cur;
  assign taken  = valid_o & ready_i;

  //////////////////////////////////////////////////
  // pc advance and pop
  //////////////////////////////////////////////////

  always_comb begin
    pc_next = pc_cur;
    if (taken) begin
      if (!unaligned && compressed) begin
        // stay in the head word, move to its upper half
        pc_next = {pc_cur[ADDR_W-1:2], 2'b10};
      end else if (unaligned && !compressed) begin
        // upper half of the second word comes next
        pc_next = {word_next[ADDR_W-1:2], 2'b10};
      end else begin
        pc_next = word_next;
      end
    end
  end

  // head word is used up unless only its lower parcel went out
  assign pop_o = taken & (unaligned | ~compressed);

  // follows the bypass address too, so it is right once the word is stored
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

endmodule

`default_nettype wire

/* rtl/fetch_queue.sv */
// fetch queue: stores returned words and bypasses the incoming word to the aligner
`default_nettype none

module fetch_queue (
  input  wire logic                 clk,
  input  wire logic                 rst_n,

  // from the fetch controller
  input  wire logic                 clear_i,
  input  wire logic                 push_i,
  input  wire prefetch_pkg::addr_t  push_addr_i,
  input  wire prefetch_pkg::word_t  push_data_i,

  // from the aligner, one strobe per consumed word
  input  wire logic                 pop_i,

  output logic                      space_o,
  output prefetch_pkg::word_t       head_o,
  output logic                      head_valid_o,
  output logic                      head_stored_o,
  output prefetch_pkg::word_t       second_o,
  output logic                      second_valid_o,
  output prefetch_pkg::addr_t       in_addr_o
);

  import prefetch_pkg::*;

  // entry 0 is the head
  word_t                  data_q [0:QUEUE_DEPTH-1];
  word_t                  data_d [0:QUEUE_DEPTH-1];
  logic [QUEUE_DEPTH-1:0] valid_q;
  logic [QUEUE_DEPTH-1:0] valid_d;

  //////////////////////////////////////////////////
  // output side with bypass
  //////////////////////////////////////////////////

  // incoming word takes the place of the first empty slot
  assign head_o        = valid_q[0] ? data_q[0] : push_data_i;
  assign head_valid_o  = valid_q[0] | push_i;
  assign head_stored_o = valid_q[0];

  assign second_o       = valid_q[1] ? data_q[1] : push_data_i;
  assign second_valid_o = valid_q[1] | (valid_q[0] & push_i);

  // address of the word arriving now
  assign in_addr_o = push_addr_i;

  // one response may still be in flight, keep the last slot for it
  assign space_o = ~valid_q[QUEUE_DEPTH-2];

  //////////////////////////////////////////////////
  // push then pop
  //////////////////////////////////////////////////

  always_comb begin
    logic placed;

    placed  = 1'b0;
    data_d  = data_q;
    valid_d = valid_q;

    // write the first free entry
    if (push_i) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
        if (!valid_q[i] && !placed) begin
          data_d[i]  = push_data_i;
          valid_d[i] = 1'b1;
          placed     = 1'b1;
        end
      end
    end

    // shift everything up by one entry
    if (pop_i) begin
      for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
        data_d[i]  = data_d[i+1];
        valid_d[i] = valid_d[i+1];
      end
      valid_d[QUEUE_DEPTH-1] = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (clear_i) begin
      // branch, start over from an empty queue
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // payload only, qualified by valid_q
  always_ff @(posedge clk) begin
    data_q <= data_d;
  end

endmodule

`default_nettype wire

/* rtl/fetch_ctrl.sv */
// fetch controller: drives the req/gnt/rvalid memory port and walks word addresses for the queue
`default_nettype none

module fetch_ctrl (
  input  wire logic                 clk,
  input  wire logic                 rst_n,

  // core side control
  input  wire logic                 req_i,
  input  wire logic                 branch_i,
  input  wire prefetch_pkg::addr_t  addr_i,

  // from the fetch queue
  input  wire logic                 queue_space_i,

  // memory port
  output logic                      instr_req_o,
  output prefetch_pkg::addr_t       instr_addr_o,
  input  wire logic                 instr_gnt_i,
  input  wire logic                 instr_rvalid_i,

  // to the fetch queue
  output logic                      push_o,
  output prefetch_pkg::addr_t       push_addr_o,
  output logic                      clear_o,

  output logic                      busy_o
);

  import prefetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  // address of the last issued (or replaced) request
  addr_t addr_q;
  // sequential successor of addr_q
  addr_t fetch_addr;
  // load instr_addr_o into addr_q at the next edge
  logic  addr_load;
  // a new fetch is wanted and allowed this cycle
  logic  fetch_ok;

  //////////////////////////////////////////////////
  // next address and status
  //////////////////////////////////////////////////

  // drop the halfword offset so an unaligned branch target
  // still continues on the following word
  assign fetch_addr = {addr_q[ADDR_W-1:2], 2'b00} + addr_t'(WORD_BYTES);

  assign fetch_ok = req_i & (queue_space_i | branch_i);

  // a branch always flushes whatever the queue holds
  assign clear_o = branch_i;

  // the response always belongs to the address issued last
  assign push_addr_o = addr_q;

  assign busy_o = (state_q != FETCH_IDLE) | instr_req_o;

  //////////////////////////////////////////////////
  // fetch FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    instr_req_o  = 1'b0;
    instr_addr_o = branch_i ? addr_i : fetch_addr;
    addr_load    = 1'b0;
    push_o       = 1'b0;

    case (state_q)
      FETCH_IDLE: begin
        // nothing outstanding, request as soon as allowed
        if (fetch_ok) begin
          instr_req_o = 1'b1;
          addr_load   = 1'b1;
          state_d     = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
        end
      end

      FETCH_WAIT_GNT: begin
        // address holds until granted, a branch may still replace it
        instr_req_o  = 1'b1;
        instr_addr_o = branch_i ? addr_i : addr_q;
        addr_load    = branch_i;
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT_RVALID;
        end
      end

      FETCH_WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          // response in a branch cycle is stale, the clear drops the rest
          push_o = ~branch_i;
          if (fetch_ok) begin
            // back-to-back fetch in the rvalid cycle
            instr_req_o = 1'b1;
            addr_load   = 1'b1;
            state_d     = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
          end else begin
            state_d = FETCH_IDLE;
          end
        end else if (branch_i) begin
          // keep the target, the old response must still drain
          addr_load = 1'b1;
          state_d   = FETCH_WAIT_ABORTED;
        end
      end

      FETCH_WAIT_ABORTED: begin
        // later branches overwrite the stored target
        instr_addr_o = branch_i ? addr_i : addr_q;
        addr_load    = branch_i;
        if (instr_rvalid_i) begin
          // stale word is dropped, request the target right away
          instr_req_o = 1'b1;
          state_d     = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
        end
      end

      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= FETCH_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (addr_load) begin
        addr_q <= instr_addr_o;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/prefetch_pkg.sv */
// shared widths, queue depth, data types and fetch states; imported by every prefetch RTL module
`default_nettype none

package prefetch_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // byte address on both memory and core side
  localparam int ADDR_W = 32;
  // one memory word per response
  localparam int WORD_W = 32;
  // one instruction parcel, a compressed instruction is one parcel
  localparam int HALF_W = 16;

  // word entries in the fetch queue, needs at least 3
  // so an outstanding response always finds a free slot
  localparam int QUEUE_DEPTH = 4;

  // address step between consecutive memory words
  localparam int WORD_BYTES = 4;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;

  // memory-side fetch FSM
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT_GNT,
    FETCH_WAIT_RVALID,
    // branch seen while a response was outstanding
    FETCH_WAIT_ABORTED
  } fetch_state_e;

endpackage

`default_nettype wire
